/* all.f */
+incdir+rtl
rtl/idu_pkg.sv
rtl/imm_gen.sv
rtl/op_decoder.sv
rtl/operand_bypass.sv
rtl/decode_stage_reg.sv
rtl/idu_top.sv
bench/idu_tb.sv

/* bench/idu_tb.sv */
`timescale 1ns/1ps
`include "idu_params.svh"

module idu_tb;

    logic                       clk;
    logic                       reset_i;
    logic                       fetch_valid_i;
    idu_pkg::fetch_pkt_t        fetch_pkt_i;
    logic                       fetch_ready_o;
    logic                       flush_i;
    logic [`IDU_REG_ADDR_W-1:0] rf_rs1_addr_o;
    logic [`IDU_REG_ADDR_W-1:0] rf_rs2_addr_o;
    logic [`IDU_XLEN-1:0]       rf_rs1_data_i;
    logic [`IDU_XLEN-1:0]       rf_rs2_data_i;
    idu_pkg::wb_bus_t           alu_wb_i;
    idu_pkg::wb_bus_t           lsu_wb_i;
    idu_pkg::rf_wr_t            rf_wr_i;
    logic                       exec_valid_o;
    logic                       exec_ready_i;
    idu_pkg::decoded_pkt_t      exec_pkt_o;

    idu_top idu_top_inst (.*);

    // xN holds N * 0x01010101
    assign rf_rs1_data_i = rf_rs1_addr_o * 32'h0101_0101;
    assign rf_rs2_data_i = rf_rs2_addr_o * 32'h0101_0101;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [4:0] rand_reg();
        return 5'($urandom);
    endfunction

    // immediate value that the format can express
    function automatic logic [31:0] legal_imm(input byte fmt, input logic [31:0] raw);
        case (fmt)
            "I", "S": return {{20{raw[11]}}, raw[11:0]};
            "B":      return {{19{raw[12]}}, raw[12:1], 1'b0};
            "U":      return {raw[31:12], 12'h0};
            default:  return {{11{raw[20]}}, raw[20:1], 1'b0};
        endcase
    endfunction

    function automatic logic [31:0] encode(input byte fmt, input logic [31:0] imm,
                                           input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [6:0] op7);
        case (fmt)
            "R":     return {f7, rs2, rs1, f3, rd, op7};
            "I":     return {imm[11:0], rs1, f3, rd, op7};
            "S":     return {imm[11:5], rs2, rs1, f3, imm[4:0], op7};
            "B":     return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op7};
            "U":     return {imm[31:12], rd, op7};
            default: return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op7};
        endcase
    endfunction

    // alu bus first, then load/store bus, then write port, then register file
    function automatic logic [31:0] pick_src(input logic [4:0] a, input logic used);
        if (!used || a == 5'd0) return a * 32'h0101_0101;
        if (alu_wb_i.valid && alu_wb_i.addr == a) return alu_wb_i.data;
        if (lsu_wb_i.valid && lsu_wb_i.addr == a) return lsu_wb_i.data;
        if (rf_wr_i.valid && rf_wr_i.addr == a) return rf_wr_i.data;
        return a * 32'h0101_0101;
    endfunction

    task automatic check_eq(input string name, input logic [31:0] exp_v,
                            input logic [31:0] act_v);
        if (exp_v !== act_v) begin
            $display("FAILED %s: expected %h, actual %h", name, exp_v, act_v);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "timeout");
    endtask

    task automatic send_instr(input logic [31:0] instr, input logic [31:0] pc);
        int waited;
        waited = 0;
        @(posedge clk);
        fetch_valid_i     <= 1'b1;
        fetch_pkt_i.instr <= instr;
        fetch_pkt_i.pc    <= pc;
        @(negedge clk);
        while (!fetch_ready_o && waited < 20) begin
            waited++;
            @(negedge clk);
        end
        if (!fetch_ready_o) begin
            report_timeout("fetch_ready_o");
        end else begin
            @(posedge clk);
            fetch_valid_i <= 1'b0;
        end
    endtask

    // called right after the accepting edge
    task automatic expect_pkt(input string name, input idu_pkg::decoded_pkt_t exp_p);
        @(negedge clk);
        check_eq({name, " valid"}, 32'd1, 32'(exec_valid_o));
        check_eq({name, " alu_op"}, 32'(exp_p.alu_op), 32'(exec_pkt_o.alu_op));
        check_eq({name, " wb_valid"}, 32'(exp_p.wb_valid), 32'(exec_pkt_o.wb_valid));
        check_eq({name, " rd"}, 32'(exp_p.rd), 32'(exec_pkt_o.rd));
        check_eq({name, " src1"}, exp_p.src1, exec_pkt_o.src1);
        check_eq({name, " src2"}, exp_p.src2, exec_pkt_o.src2);
        check_eq({name, " br_st_imm"}, exp_p.br_st_imm, exec_pkt_o.br_st_imm);
        check_eq({name, " pc"}, exp_p.pc, exec_pkt_o.pc);
    endtask

    task automatic run_case(input string name, input byte fmt, input logic [6:0] op7,
                            input logic [2:0] f3, input logic [6:0] f7,
                            input idu_pkg::alu_op_e exp_op, input logic [4:0] rs1,
                            input logic [4:0] rs2, input logic [31:0] raw);
        logic [31:0]           imm;
        logic [31:0]           instr;
        logic [31:0]           pc;
        logic                  uses1;
        logic                  uses2;
        idu_pkg::decoded_pkt_t exp_p;
        imm   = legal_imm(fmt, raw);
        instr = encode(fmt, imm, f7, rs2, rs1, f3, rand_reg(), op7);
        pc    = $urandom & ~32'h3;
        uses1 = (fmt != "U") && (fmt != "J");
        uses2 = (fmt == "R") || (fmt == "S") || (fmt == "B");
        send_instr(instr, pc);
        exp_p.alu_op    = exp_op;
        exp_p.wb_valid  = (fmt != "S") && (fmt != "B");
        exp_p.rd        = instr[11:7];
        exp_p.src1      = pick_src(instr[19:15], uses1);
        exp_p.src2      = uses2 ? pick_src(instr[24:20], 1'b1) : imm;
        exp_p.br_st_imm = (fmt == "S" || fmt == "B") ? imm : 32'h0;
        exp_p.pc        = pc;
        expect_pkt(name, exp_p);
    endtask

    task automatic random_case(input string name, input byte fmt, input logic [6:0] op7,
                               input logic [2:0] f3, input logic [6:0] f7,
                               input idu_pkg::alu_op_e exp_op, input logic neg);
        logic [31:0] raw;
        // bits 11, 12, 20 and 31 carry the sign of every immediate format
        raw = neg ? ($urandom | 32'h8010_1800) : ($urandom & ~32'h8010_1800);
        run_case(name, fmt, op7, f3, f7, exp_op, rand_reg(), rand_reg(), raw);
    endtask

    task automatic basic_decode(input logic neg);
        random_case("add", "R", idu_pkg::OP, 3'd0, 7'h00, idu_pkg::ALU_ADD, neg);
        random_case("sub", "R", idu_pkg::OP, 3'd0, 7'h20, idu_pkg::ALU_SUB, neg);
        random_case("sll", "R", idu_pkg::OP, 3'd1, 7'h00, idu_pkg::ALU_SLL, neg);
        random_case("sra", "R", idu_pkg::OP, 3'd5, 7'h20, idu_pkg::ALU_SRA, neg);
        random_case("addi", "I", idu_pkg::OP_IMM, 3'd0, 7'h00, idu_pkg::ALU_ADD, neg);
        random_case("lw", "I", idu_pkg::LOAD, 3'd2, 7'h00, idu_pkg::ALU_LW, neg);
        random_case("sw", "S", idu_pkg::STORE, 3'd2, 7'h00, idu_pkg::ALU_SW, neg);
        random_case("beq", "B", idu_pkg::BRANCH, 3'd0, 7'h00, idu_pkg::ALU_BEQ, neg);
        random_case("lui", "U", idu_pkg::LUI, 3'd0, 7'h00, idu_pkg::ALU_LUI, neg);
        random_case("auipc", "U", idu_pkg::AUIPC, 3'd0, 7'h00, idu_pkg::ALU_AUIPC, neg);
        random_case("jal", "J", idu_pkg::JAL, 3'd0, 7'h00, idu_pkg::ALU_JAL, neg);
        random_case("jalr", "I", idu_pkg::JALR, 3'd0, 7'h00, idu_pkg::ALU_JALR, neg);
    endtask

    task automatic bypass_priority();
        logic [4:0] a;
        a = 5'($urandom_range(31, 1));
        // drop one bus per pass, highest priority first
        for (int k = 0; k < 4; k++) begin
            @(posedge clk);
            alu_wb_i <= {k < 1, 1'b0, a, $urandom};
            lsu_wb_i <= {k < 2, 1'b0, a, $urandom};
            rf_wr_i  <= {k < 3, a, $urandom};
            run_case("bypass", "R", idu_pkg::OP, 3'd0, 7'h00, idu_pkg::ALU_ADD,
                     a, rand_reg(), $urandom);
        end
        @(posedge clk);
        alu_wb_i <= {1'b1, 1'b0, 5'd0, $urandom};
        lsu_wb_i <= {1'b1, 1'b0, 5'd0, $urandom};
        rf_wr_i  <= {1'b1, 5'd0, $urandom};
        run_case("x0 dest", "R", idu_pkg::OP, 3'd0, 7'h00, idu_pkg::ALU_ADD,
                 5'd0, 5'd0, $urandom);
        // load bus on a field that the format does not read
        @(posedge clk);
        alu_wb_i <= {1'b1, 1'b0, a, $urandom};
        lsu_wb_i <= {1'b1, 1'b1, a, $urandom};
        rf_wr_i  <= {1'b1, a, $urandom};
        run_case("unused rs1", "U", idu_pkg::LUI, 3'd0, 7'h00, idu_pkg::ALU_LUI,
                 5'd0, 5'd0, {12'($urandom), a, 15'($urandom)});
        run_case("unused rs2", "I", idu_pkg::OP_IMM, 3'd0, 7'h00, idu_pkg::ALU_ADD,
                 5'd0, 5'd0, {27'($urandom), a});
        @(posedge clk);
        alu_wb_i <= '0;
        lsu_wb_i <= '0;
        rf_wr_i  <= '0;
    endtask

    task automatic load_use_stall();
        logic [4:0] a;
        a = 5'($urandom_range(31, 1));
        @(posedge clk);
        lsu_wb_i <= {1'b1, 1'b1, a, $urandom};
        fork
            begin
                @(posedge clk);
                repeat (3) begin
                    @(negedge clk);
                    check_eq("load-use ready", 32'd0, 32'(fetch_ready_o));
                    check_eq("load-use valid", 32'd0, 32'(exec_valid_o));
                end
                @(posedge clk);
                lsu_wb_i.valid <= 1'b0;
            end
            run_case("load-use", "R", idu_pkg::OP, 3'd0, 7'h00, idu_pkg::ALU_ADD,
                     rand_reg(), a, $urandom);
        join
    endtask

    task automatic backpressure_flush();
        idu_pkg::decoded_pkt_t held_pkt;
        logic [31:0]           instr;
        instr = encode("R", 32'h0, 7'h20, rand_reg(), rand_reg(), 3'd0, rand_reg(), idu_pkg::OP);
        @(posedge clk);
        exec_ready_i <= 1'b0;
        random_case("held", "R", idu_pkg::OP, 3'd4, 7'h00, idu_pkg::ALU_XOR, 1'b0);
        held_pkt = exec_pkt_o;
        // a new offer waits behind the held packet
        @(posedge clk);
        fetch_valid_i     <= 1'b1;
        fetch_pkt_i.instr <= instr;
        fetch_pkt_i.pc    <= 32'h0000_0100;
        repeat (3) begin
            @(negedge clk);
            check_eq("held valid", 32'd1, 32'(exec_valid_o));
            check_eq("held stable", 32'd1, 32'(exec_pkt_o === held_pkt));
            check_eq("held ready", 32'd0, 32'(fetch_ready_o));
        end
        @(posedge clk);
        fetch_valid_i <= 1'b0;
        exec_ready_i  <= 1'b1;
        flush_i       <= 1'b1;
        send_instr(instr, 32'h0000_0100);
        flush_i <= 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_eq("flushed valid", 32'd0, 32'(exec_valid_o));
        end
    endtask

    initial begin
        void'($urandom(32'h642c_0f3a));
        reset_i       = 1'b1;
        fetch_valid_i = 1'b0;
        fetch_pkt_i   = '0;
        flush_i       = 1'b0;
        alu_wb_i      = '0;
        lsu_wb_i      = '0;
        rf_wr_i       = '0;
        exec_ready_i  = 1'b1;
        repeat (4) @(posedge clk);
        reset_i <= 1'b0;
        @(negedge clk);
        check_eq("reset valid", 32'd0, 32'(exec_valid_o));
        check_eq("reset ready", 32'd1, 32'(fetch_ready_o));
        basic_decode(1'b0);
        basic_decode(1'b1);
        bypass_priority();
        load_use_stall();
        backpressure_flush();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* rtl/decode_stage_reg.sv */
`timescale 1ns/1ps

module decode_stage_reg (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  in_valid_i,
    input  logic                  flush_i,
    input  idu_pkg::decoded_pkt_t pkt_i,
    input  logic                  out_ready_i,
    input  logic                  stall_i,
    output logic                  in_ready_o,
    output logic                  out_valid_o,
    output idu_pkg::decoded_pkt_t pkt_o
);

    logic accept;
    logic load;

    // slot is free when empty or draining this cycle
    assign in_ready_o = (out_ready_i || !out_valid_o) && !stall_i;
    assign accept     = in_valid_i && in_ready_o;

    // flushed instruction is consumed but dropped
    assign load = accept && !flush_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            out_valid_o <= 1'b0;
        end else if (load) begin
            out_valid_o <= 1'b1;
        end else if (out_ready_i) begin
            out_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            pkt_o <= pkt_i;
        end
    end

endmodule

/* rtl/idu_params.svh */
`ifndef IDU_PARAMS_SVH
`define IDU_PARAMS_SVH

// datapath and instruction width
`define IDU_XLEN        32

// register file address
`define IDU_REG_ADDR_W  5

// field widths
`define IDU_OPCODE_W    7
`define IDU_FUNCT3_W    3
`define IDU_FUNCT7_W    7

// field positions in a 32-bit instruction
`define IDU_OPCODE_RNG  6:0
`define IDU_RD_RNG      11:7
`define IDU_FUNCT3_RNG  14:12
`define IDU_RS1_RNG     19:15
`define IDU_RS2_RNG     24:20
`define IDU_FUNCT7_RNG  31:25

`endif

/* rtl/idu_pkg.sv */
`include "idu_params.svh"

package idu_pkg;

    // rv32i major opcodes
    typedef enum logic [`IDU_OPCODE_W-1:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111
    } opcode_e;

    // one operation per decoded instruction
    typedef enum logic [4:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_OR, ALU_AND,
        ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU,
        ALU_LB, ALU_LH, ALU_LW, ALU_LBU, ALU_LHU,
        ALU_SB, ALU_SH, ALU_SW,
        ALU_LUI, ALU_AUIPC, ALU_JAL, ALU_JALR,
        ALU_NONE = 5'd31
    } alu_op_e;

    typedef struct packed {
        logic [`IDU_XLEN-1:0] instr;
        logic [`IDU_XLEN-1:0] pc;
    } fetch_pkt_t;

    // bypass from alu or load/store unit
    typedef struct packed {
        logic                       valid;
        logic                       is_load;
        logic [`IDU_REG_ADDR_W-1:0] addr;
        logic [`IDU_XLEN-1:0]       data;
    } wb_bus_t;

    typedef struct packed {
        logic                       valid;
        logic [`IDU_REG_ADDR_W-1:0] addr;
        logic [`IDU_XLEN-1:0]       data;
    } rf_wr_t;

    typedef struct packed {
        alu_op_e alu_op;
        logic    wb_valid;
        logic    uses_rs1;
        logic    uses_rs2;
        logic    src2_is_imm;
    } decode_ctl_t;

    typedef struct packed {
        alu_op_e                    alu_op;
        logic                       wb_valid;
        logic [`IDU_REG_ADDR_W-1:0] rd;
        logic [`IDU_XLEN-1:0]       src1;
        logic [`IDU_XLEN-1:0]       src2;
        logic [`IDU_XLEN-1:0]       br_st_imm;
        logic [`IDU_XLEN-1:0]       pc;
    } decoded_pkt_t;

endpackage

/* rtl/idu_top.sv */
`timescale 1ns/1ps
`include "idu_params.svh"

module idu_top (
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic                       fetch_valid_i,
    input  idu_pkg::fetch_pkt_t        fetch_pkt_i,
    output logic                       fetch_ready_o,
    input  logic                       flush_i,
    output logic [`IDU_REG_ADDR_W-1:0] rf_rs1_addr_o,
    output logic [`IDU_REG_ADDR_W-1:0] rf_rs2_addr_o,
    input  logic [`IDU_XLEN-1:0]       rf_rs1_data_i,
    input  logic [`IDU_XLEN-1:0]       rf_rs2_data_i,
    input  idu_pkg::wb_bus_t           alu_wb_i,
    input  idu_pkg::wb_bus_t           lsu_wb_i,
    input  idu_pkg::rf_wr_t            rf_wr_i,
    output logic                       exec_valid_o,
    input  logic                       exec_ready_i,
    output idu_pkg::decoded_pkt_t      exec_pkt_o
);

    logic [`IDU_XLEN-1:0]  imm;
    logic [`IDU_XLEN-1:0]  br_st_imm;
    logic [`IDU_XLEN-1:0]  src1;
    logic [`IDU_XLEN-1:0]  src2_reg;
    logic                  load_hazard;
    idu_pkg::decode_ctl_t  ctl;
    idu_pkg::decoded_pkt_t dec_pkt;

    // register file read in the same cycle as the offer
    assign rf_rs1_addr_o = fetch_pkt_i.instr[`IDU_RS1_RNG];
    assign rf_rs2_addr_o = fetch_pkt_i.instr[`IDU_RS2_RNG];

    imm_gen imm_gen_inst (
        .instr_i     (fetch_pkt_i.instr),
        .imm_o       (imm),
        .br_st_imm_o (br_st_imm)
    );

    op_decoder op_decoder_inst (
        .instr_i (fetch_pkt_i.instr),
        .ctl_o   (ctl)
    );

    operand_bypass operand_bypass_inst (
        .rs1_addr_i    (rf_rs1_addr_o),
        .rs2_addr_i    (rf_rs2_addr_o),
        .uses_rs1_i    (ctl.uses_rs1),
        .uses_rs2_i    (ctl.uses_rs2),
        .rs1_data_i    (rf_rs1_data_i),
        .rs2_data_i    (rf_rs2_data_i),
        .alu_wb_i      (alu_wb_i),
        .lsu_wb_i      (lsu_wb_i),
        .rf_wr_i       (rf_wr_i),
        .src1_o        (src1),
        .src2_reg_o    (src2_reg),
        .load_hazard_o (load_hazard)
    );

    always_comb begin
        dec_pkt.alu_op    = ctl.alu_op;
        dec_pkt.wb_valid  = ctl.wb_valid;
        dec_pkt.rd        = fetch_pkt_i.instr[`IDU_RD_RNG];
        dec_pkt.src1      = src1;
        dec_pkt.src2      = ctl.src2_is_imm ? imm : src2_reg;
        dec_pkt.br_st_imm = br_st_imm;
        dec_pkt.pc        = fetch_pkt_i.pc;
    end

    decode_stage_reg decode_stage_reg_inst (
        .clk         (clk),
        .reset_i     (reset_i),
        .in_valid_i  (fetch_valid_i),
        .flush_i     (flush_i),
        .pkt_i       (dec_pkt),
        .out_ready_i (exec_ready_i),
        .stall_i     (load_hazard),
        .in_ready_o  (fetch_ready_o),
        .out_valid_o (exec_valid_o),
        .pkt_o       (exec_pkt_o)
    );

endmodule

/* rtl/imm_gen.sv */
`timescale 1ns/1ps
`include "idu_params.svh"

module imm_gen (
    input  logic [`IDU_XLEN-1:0] instr_i,
    output logic [`IDU_XLEN-1:0] imm_o,
    output logic [`IDU_XLEN-1:0] br_st_imm_o
);

    idu_pkg::opcode_e     opcode;
    logic [`IDU_XLEN-1:0] i_imm;
    logic [`IDU_XLEN-1:0] s_imm;
    logic [`IDU_XLEN-1:0] b_imm;
    logic [`IDU_XLEN-1:0] u_imm;
    logic [`IDU_XLEN-1:0] j_imm;

    assign opcode = idu_pkg::opcode_e'(instr_i[`IDU_OPCODE_RNG]);

    // sign bit is always instr[31]
    assign i_imm = {{20{instr_i[31]}}, instr_i[31:20]};
    assign s_imm = {{20{instr_i[31]}}, instr_i[`IDU_FUNCT7_RNG], instr_i[`IDU_RD_RNG]};
    assign b_imm = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign u_imm = {instr_i[31:12], 12'b0};
    assign j_imm = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};

    always_comb begin
        imm_o       = '0;
        br_st_imm_o = '0;
        case (opcode)
            idu_pkg::OP_IMM, idu_pkg::LOAD, idu_pkg::JALR: imm_o = i_imm;
            idu_pkg::LUI, idu_pkg::AUIPC:                   imm_o = u_imm;
            idu_pkg::JAL:                                   imm_o = j_imm;
            idu_pkg::STORE: begin
                imm_o       = s_imm;
                br_st_imm_o = s_imm;
            end
            idu_pkg::BRANCH: begin
                imm_o       = b_imm;
                br_st_imm_o = b_imm;
            end
            default: ;
        endcase
    end

endmodule

/* rtl/op_decoder.sv */
`timescale 1ns/1ps
`include "idu_params.svh"

module op_decoder (
    input  logic [`IDU_XLEN-1:0] instr_i,
    output idu_pkg::decode_ctl_t ctl_o
);

    localparam logic [`IDU_FUNCT7_W-1:0] F7_BASE = 7'b0000000;
    localparam logic [`IDU_FUNCT7_W-1:0] F7_ALT  = 7'b0100000;

    idu_pkg::opcode_e          opcode;
    logic [`IDU_FUNCT3_W-1:0]  funct3;
    logic [`IDU_FUNCT7_W-1:0]  funct7;

    assign opcode = idu_pkg::opcode_e'(instr_i[`IDU_OPCODE_RNG]);
    assign funct3 = instr_i[`IDU_FUNCT3_RNG];
    assign funct7 = instr_i[`IDU_FUNCT7_RNG];

    always_comb begin
        ctl_o        = '0;
        ctl_o.alu_op = idu_pkg::ALU_NONE;
        case (opcode)
            idu_pkg::OP: begin
                ctl_o.uses_rs1 = 1'b1;
                ctl_o.uses_rs2 = 1'b1;
                ctl_o.wb_valid = 1'b1;
                if (funct7 == F7_BASE) begin
                    case (funct3)
                        3'b000:  ctl_o.alu_op = idu_pkg::ALU_ADD;
                        3'b001:  ctl_o.alu_op = idu_pkg::ALU_SLL;
                        3'b010:  ctl_o.alu_op = idu_pkg::ALU_SLT;
                        3'b011:  ctl_o.alu_op = idu_pkg::ALU_SLTU;
                        3'b100:  ctl_o.alu_op = idu_pkg::ALU_XOR;
                        3'b101:  ctl_o.alu_op = idu_pkg::ALU_SRL;
                        3'b110:  ctl_o.alu_op = idu_pkg::ALU_OR;
                        default: ctl_o.alu_op = idu_pkg::ALU_AND;
                    endcase
                end else if (funct7 == F7_ALT && funct3 == 3'b000) begin
                    ctl_o.alu_op = idu_pkg::ALU_SUB;
                end else if (funct7 == F7_ALT && funct3 == 3'b101) begin
                    ctl_o.alu_op = idu_pkg::ALU_SRA;
                end
            end
            idu_pkg::OP_IMM: begin
                ctl_o.uses_rs1    = 1'b1;
                ctl_o.src2_is_imm = 1'b1;
                ctl_o.wb_valid    = 1'b1;
                case (funct3)
                    // no subi, so 000 is always add
                    3'b000: ctl_o.alu_op = idu_pkg::ALU_ADD;
                    3'b010: ctl_o.alu_op = idu_pkg::ALU_SLT;
                    3'b011: ctl_o.alu_op = idu_pkg::ALU_SLTU;
                    3'b100: ctl_o.alu_op = idu_pkg::ALU_XOR;
                    3'b110: ctl_o.alu_op = idu_pkg::ALU_OR;
                    3'b111: ctl_o.alu_op = idu_pkg::ALU_AND;
                    3'b001: begin
                        if (funct7 == F7_BASE) ctl_o.alu_op = idu_pkg::ALU_SLL;
                    end
                    default: begin
                        if (funct7 == F7_BASE) ctl_o.alu_op = idu_pkg::ALU_SRL;
                        else if (funct7 == F7_ALT) ctl_o.alu_op = idu_pkg::ALU_SRA;
                    end
                endcase
            end
            idu_pkg::LOAD: begin
                ctl_o.uses_rs1    = 1'b1;
                ctl_o.src2_is_imm = 1'b1;
                ctl_o.wb_valid    = 1'b1;
                case (funct3)
                    3'b000:  ctl_o.alu_op = idu_pkg::ALU_LB;
                    3'b001:  ctl_o.alu_op = idu_pkg::ALU_LH;
                    3'b010:  ctl_o.alu_op = idu_pkg::ALU_LW;
                    3'b100:  ctl_o.alu_op = idu_pkg::ALU_LBU;
                    3'b101:  ctl_o.alu_op = idu_pkg::ALU_LHU;
                    default: ctl_o.alu_op = idu_pkg::ALU_NONE;
                endcase
            end
            idu_pkg::STORE: begin
                ctl_o.uses_rs1 = 1'b1;
                ctl_o.uses_rs2 = 1'b1;
                case (funct3)
                    3'b000:  ctl_o.alu_op = idu_pkg::ALU_SB;
                    3'b001:  ctl_o.alu_op = idu_pkg::ALU_SH;
                    3'b010:  ctl_o.alu_op = idu_pkg::ALU_SW;
                    default: ctl_o.alu_op = idu_pkg::ALU_NONE;
                endcase
            end
            idu_pkg::BRANCH: begin
                ctl_o.uses_rs1 = 1'b1;
                ctl_o.uses_rs2 = 1'b1;
                case (funct3)
                    3'b000:  ctl_o.alu_op = idu_pkg::ALU_BEQ;
                    3'b001:  ctl_o.alu_op = idu_pkg::ALU_BNE;
                    3'b100:  ctl_o.alu_op = idu_pkg::ALU_BLT;
                    3'b101:  ctl_o.alu_op = idu_pkg::ALU_BGE;
                    3'b110:  ctl_o.alu_op = idu_pkg::ALU_BLTU;
                    3'b111:  ctl_o.alu_op = idu_pkg::ALU_BGEU;
                    default: ctl_o.alu_op = idu_pkg::ALU_NONE;
                endcase
            end
            idu_pkg::LUI, idu_pkg::AUIPC, idu_pkg::JAL: begin
                ctl_o.src2_is_imm = 1'b1;
                ctl_o.wb_valid    = 1'b1;
                if (opcode == idu_pkg::LUI) ctl_o.alu_op = idu_pkg::ALU_LUI;
                else if (opcode == idu_pkg::AUIPC) ctl_o.alu_op = idu_pkg::ALU_AUIPC;
                else ctl_o.alu_op = idu_pkg::ALU_JAL;
            end
            idu_pkg::JALR: begin
                ctl_o.uses_rs1    = 1'b1;
                ctl_o.src2_is_imm = 1'b1;
                ctl_o.wb_valid    = 1'b1;
                if (funct3 == 3'b000) ctl_o.alu_op = idu_pkg::ALU_JALR;
            end
            default: ;
        endcase
    end

endmodule

/* rtl/operand_bypass.sv */
`timescale 1ns/1ps
`include "idu_params.svh"

module operand_bypass (
    input  logic [`IDU_REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [`IDU_REG_ADDR_W-1:0] rs2_addr_i,
    input  logic                       uses_rs1_i,
    input  logic                       uses_rs2_i,
    input  logic [`IDU_XLEN-1:0]       rs1_data_i,
    input  logic [`IDU_XLEN-1:0]       rs2_data_i,
    input  idu_pkg::wb_bus_t           alu_wb_i,
    input  idu_pkg::wb_bus_t           lsu_wb_i,
    input  idu_pkg::rf_wr_t            rf_wr_i,
    output logic [`IDU_XLEN-1:0]       src1_o,
    output logic [`IDU_XLEN-1:0]       src2_reg_o,
    output logic                       load_hazard_o
);

    logic alu_hit1;
    logic lsu_hit1;
    logic rf_hit1;
    logic alu_hit2;
    logic lsu_hit2;
    logic rf_hit2;

    // x0 never forwards, and neither does an unused source
    function automatic logic bus_hit(
        input logic                       vld,
        input logic [`IDU_REG_ADDR_W-1:0] bus_addr,
        input logic [`IDU_REG_ADDR_W-1:0] src_addr,
        input logic                       used
    );
        return vld && used && (bus_addr == src_addr) && (src_addr != '0);
    endfunction

    assign alu_hit1 = bus_hit(alu_wb_i.valid, alu_wb_i.addr, rs1_addr_i, uses_rs1_i);
    assign lsu_hit1 = bus_hit(lsu_wb_i.valid, lsu_wb_i.addr, rs1_addr_i, uses_rs1_i);
    assign rf_hit1  = bus_hit(rf_wr_i.valid, rf_wr_i.addr, rs1_addr_i, uses_rs1_i);
    assign alu_hit2 = bus_hit(alu_wb_i.valid, alu_wb_i.addr, rs2_addr_i, uses_rs2_i);
    assign lsu_hit2 = bus_hit(lsu_wb_i.valid, lsu_wb_i.addr, rs2_addr_i, uses_rs2_i);
    assign rf_hit2  = bus_hit(rf_wr_i.valid, rf_wr_i.addr, rs2_addr_i, uses_rs2_i);

    // youngest result first
    assign src1_o = alu_hit1 ? alu_wb_i.data :
                    lsu_hit1 ? lsu_wb_i.data :
                    rf_hit1  ? rf_wr_i.data  :
                               rs1_data_i;

    assign src2_reg_o = alu_hit2 ? alu_wb_i.data :
                        lsu_hit2 ? lsu_wb_i.data :
                        rf_hit2  ? rf_wr_i.data  :
                                   rs2_data_i;

    // load data not back yet
    assign load_hazard_o = alu_wb_i.is_load && (alu_hit1 || alu_hit2) ||
                           lsu_wb_i.is_load && (lsu_hit1 || lsu_hit2);

endmodule
